//--- regex_pkg.sv
////////////////////////////////////////////////////////////////////////////
// shared formats of the regex basic block
// PCs, characters, the 16-bit instruction word and the tagged PC used
// on the input and output PC ports; modules refer to them as regex_pkg::name
////////////////////////////////////////////////////////////////////////////
package regex_pkg;

    // a PC is as wide as the instruction operand
    localparam int PC_WIDTH        = 8;
    localparam int CHARACTER_WIDTH = 8;
    localparam int I_WIDTH         = 16;

    typedef logic [PC_WIDTH-1:0]        pc_t;
    typedef logic [CHARACTER_WIDTH-1:0] char_t;

    // codes above OP_JMP are illegal and emit nothing
    typedef enum logic [2:0] {
        OP_ACCEPT = 3'd0,
        OP_CHAR   = 3'd1,
        OP_SPLIT  = 3'd2,
        OP_JMP    = 3'd3
    } opcode_e;

    // opcode in 15..13, reserved bits 12..8, operand in 7..0
    typedef struct packed {
        opcode_e                        opcode;
        logic [I_WIDTH-PC_WIDTH-4:0]    reserved;
        pc_t                            operand;
    } instr_t;

    // bit 0 set means the pc belongs to the current character
    typedef struct packed {
        pc_t  pc;
        logic current;
    } tagged_pc_t;

endpackage

//--- pc_fifo.sv
////////////////////////////////////////////////////////////////////////////
// synchronous FIFO of program counters
// valid/ready on both sides, holds 2^FIFO_COUNT_WIDTH - 1 entries so the
// occupancy count fits its width; written data shows at the head next cycle
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module pc_fifo #(
    parameter int FIFO_COUNT_WIDTH = 3
)(
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        in_valid,
    input  regex_pkg::pc_t              in_data,
    output logic                        in_ready,
    output logic                        out_valid,
    output regex_pkg::pc_t              out_data,
    input  logic                        out_ready,
    output logic [FIFO_COUNT_WIDTH-1:0] count
);
    localparam int CAPACITY = (1 << FIFO_COUNT_WIDTH) - 1;

    // one slot more than the capacity so the pointers wrap on their own
    regex_pkg::pc_t              mem [0:CAPACITY];
    logic [FIFO_COUNT_WIDTH-1:0] wr_ptr;
    logic [FIFO_COUNT_WIDTH-1:0] rd_ptr;
    logic                        push;
    logic                        pop;

    assign in_ready  = count != FIFO_COUNT_WIDTH'(CAPACITY);
    assign out_valid = count != '0;
    assign out_data  = mem[rd_ptr];
    assign push      = in_valid && in_ready;
    assign pop       = out_valid && out_ready;

    always_ff @(posedge clk)
    begin
        if (push)
        begin
            mem[wr_ptr] <= in_data;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (push)
            begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop)
            begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // simultaneous push and pop leaves the count alone
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // occupancy always equals the distance between the pointers
    a_count_matches_ptrs: assert property (@(posedge clk) disable iff (rst)
        count == FIFO_COUNT_WIDTH'(wr_ptr - rd_ptr));

    // a waiting head entry is never overwritten by a push
    a_head_stable: assert property (@(posedge clk) disable iff (rst)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_data)));

endmodule

//--- ping_pong_buffer.sv
////////////////////////////////////////////////////////////////////////////
// current and next character PC storage built from two FIFOs
// the even and odd FIFOs swap current and next roles with the parity of
// the character; the next-character side is never dequeued
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module ping_pong_buffer #(
    parameter int FIFO_COUNT_WIDTH = 3
)(
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        cur_is_even_character,
    input  logic                        cur_in_valid,
    input  regex_pkg::pc_t              cur_in_data,
    output logic                        cur_in_ready,
    output logic                        cur_out_valid,
    output regex_pkg::pc_t              cur_out_data,
    input  logic                        cur_out_ready,
    output logic [FIFO_COUNT_WIDTH-1:0] cur_count,
    input  logic                        next_in_valid,
    input  regex_pkg::pc_t              next_in_data,
    output logic                        next_in_ready
);
    // even FIFO side
    logic                        even_in_valid;
    regex_pkg::pc_t              even_in_data;
    logic                        even_in_ready;
    logic                        even_out_valid;
    regex_pkg::pc_t              even_out_data;
    logic                        even_out_ready;
    logic [FIFO_COUNT_WIDTH-1:0] even_count;
    // odd FIFO side
    logic                        odd_in_valid;
    regex_pkg::pc_t              odd_in_data;
    logic                        odd_in_ready;
    logic                        odd_out_valid;
    regex_pkg::pc_t              odd_out_data;
    logic                        odd_out_ready;
    logic [FIFO_COUNT_WIDTH-1:0] odd_count;

    ////////////////////////////////////////////////////////////////////////////
    // role steering
    ////////////////////////////////////////////////////////////////////////////

    // write side follows the parity
    assign even_in_valid = cur_is_even_character ? cur_in_valid : next_in_valid;
    assign even_in_data  = cur_is_even_character ? cur_in_data  : next_in_data;
    assign odd_in_valid  = cur_is_even_character ? next_in_valid : cur_in_valid;
    assign odd_in_data   = cur_is_even_character ? next_in_data  : cur_in_data;
    assign cur_in_ready  = cur_is_even_character ? even_in_ready : odd_in_ready;
    assign next_in_ready = cur_is_even_character ? odd_in_ready  : even_in_ready;

    // only the current role may be dequeued
    assign even_out_ready = cur_is_even_character && cur_out_ready;
    assign odd_out_ready  = !cur_is_even_character && cur_out_ready;

    assign cur_out_valid = cur_is_even_character ? even_out_valid : odd_out_valid;
    assign cur_out_data  = cur_is_even_character ? even_out_data  : odd_out_data;
    assign cur_count     = cur_is_even_character ? even_count     : odd_count;

    pc_fifo #(
        .FIFO_COUNT_WIDTH (FIFO_COUNT_WIDTH)
    ) i_even_fifo (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (even_in_valid),
        .in_data   (even_in_data),
        .in_ready  (even_in_ready),
        .out_valid (even_out_valid),
        .out_data  (even_out_data),
        .out_ready (even_out_ready),
        .count     (even_count)
    );

    pc_fifo #(
        .FIFO_COUNT_WIDTH (FIFO_COUNT_WIDTH)
    ) i_odd_fifo (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (odd_in_valid),
        .in_data   (odd_in_data),
        .in_ready  (odd_in_ready),
        .out_valid (odd_out_valid),
        .out_data  (odd_out_data),
        .out_ready (odd_out_ready),
        .count     (odd_count)
    );

endmodule

//--- instr_fetch.sv
////////////////////////////////////////////////////////////////////////////
// instruction fetch adapter between the CPU and a wider memory
// splits an instruction address into word address and slot, keeps the slot
// from the transfer and selects the 16-bit instruction from the next word
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module instr_fetch #(
    parameter int MEMORY_WIDTH      = 32,
    parameter int MEMORY_ADDR_WIDTH = 7
)(
    input  logic                         clk,
    input  logic                         fetch_valid,
    input  regex_pkg::pc_t               fetch_addr,
    output logic                         fetch_ready,
    output regex_pkg::instr_t            instr,
    output logic                         memory_valid,
    output logic [MEMORY_ADDR_WIDTH-1:0] memory_addr,
    input  logic                         memory_ready,
    input  logic [MEMORY_WIDTH-1:0]      memory_data
);
    // instructions per memory word, a power of two
    localparam int WORDS     = MEMORY_WIDTH / regex_pkg::I_WIDTH;
    localparam int SEL_WIDTH = (WORDS > 1) ? $clog2(WORDS) : 1;

    logic [SEL_WIDTH-1:0] sel_q;

    // request side is purely combinational
    assign memory_valid = fetch_valid;
    assign fetch_ready  = memory_ready;
    assign memory_addr  = MEMORY_ADDR_WIDTH'(fetch_addr / WORDS);

    // slot of the accepted request, used when the word comes back
    always_ff @(posedge clk)
    begin
        if (fetch_valid && memory_ready)
        begin
            sel_q <= SEL_WIDTH'(fetch_addr % WORDS);
        end
    end

    // low slot sits in the low bits of the word
    assign instr = regex_pkg::instr_t'(memory_data[sel_q*regex_pkg::I_WIDTH +: regex_pkg::I_WIDTH]);

endmodule

//--- regex_cpu.sv
////////////////////////////////////////////////////////////////////////////
// regex CPU executing one PC at a time
// fetches the instruction of the PC, decodes it against the current
// character and emits the resulting tagged PCs over valid/ready
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module regex_cpu (
    input  logic                     clk,
    input  logic                     rst,
    input  regex_pkg::char_t         current_character,
    input  logic                     pc_in_valid,
    input  regex_pkg::pc_t           pc_in,
    output logic                     pc_in_ready,
    output logic                     fetch_valid,
    output regex_pkg::pc_t           fetch_addr,
    input  logic                     fetch_ready,
    input  regex_pkg::instr_t        instr,
    output logic                     output_pc_valid,
    output regex_pkg::tagged_pc_t    output_pc_and_current,
    input  logic                     output_pc_ready,
    output logic                     accepts,
    output logic                     busy
);
    typedef enum logic [2:0] {
        IDLE,
        FETCH,
        DECODE,
        EMIT_FIRST,
        EMIT_SECOND
    } state_e;

    state_e         state;
    regex_pkg::pc_t pc_q;
    regex_pkg::pc_t pc_next;
    // pc and tag presented on the output
    regex_pkg::pc_t emit_pc_q;
    logic           emit_cur_q;
    // second target of a split
    regex_pkg::pc_t split_pc_q;
    logic           split_q;

    assign pc_next = pc_q + 1'b1;

    assign pc_in_ready     = state == IDLE;
    assign busy            = state != IDLE;
    assign fetch_valid     = state == FETCH;
    assign fetch_addr      = pc_q;
    assign output_pc_valid = (state == EMIT_FIRST) || (state == EMIT_SECOND);
    assign output_pc_and_current = '{pc: emit_pc_q, current: emit_cur_q};

    // match pulse lasts only the decode cycle
    assign accepts = (state == DECODE) && (instr.opcode == regex_pkg::OP_ACCEPT);

    ////////////////////////////////////////////////////////////////////////////
    // control
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state <= IDLE;
        end
        else
        begin
            case (state)
                IDLE:
                begin
                    if (pc_in_valid)
                    begin
                        pc_q  <= pc_in;
                        state <= FETCH;
                    end
                end
                // wait here until memory accepts the address
                FETCH:
                begin
                    if (fetch_ready)
                    begin
                        state <= DECODE;
                    end
                end
                // instruction word is on instr in this cycle only
                DECODE:
                begin
                    split_q    <= 1'b0;
                    split_pc_q <= instr.operand;
                    case (instr.opcode)
                        regex_pkg::OP_CHAR:
                        begin
                            // a match moves on to the next character
                            emit_pc_q  <= pc_next;
                            emit_cur_q <= 1'b0;
                            state      <= (instr.operand == current_character) ? EMIT_FIRST : IDLE;
                        end
                        regex_pkg::OP_JMP:
                        begin
                            emit_pc_q  <= instr.operand;
                            emit_cur_q <= 1'b1;
                            state      <= EMIT_FIRST;
                        end
                        regex_pkg::OP_SPLIT:
                        begin
                            // fall-through first, jump target second
                            emit_pc_q  <= pc_next;
                            emit_cur_q <= 1'b1;
                            split_q    <= 1'b1;
                            state      <= EMIT_FIRST;
                        end
                        // accept and illegal codes emit nothing
                        default:
                        begin
                            state <= IDLE;
                        end
                    endcase
                end
                EMIT_FIRST:
                begin
                    if (output_pc_ready)
                    begin
                        emit_pc_q <= split_pc_q;
                        state     <= split_q ? EMIT_SECOND : IDLE;
                    end
                end
                EMIT_SECOND:
                begin
                    if (output_pc_ready)
                    begin
                        state <= IDLE;
                    end
                end
                default:
                begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // a stalled output keeps its pc and tag until taken
    a_output_stable: assert property (@(posedge clk) disable iff (rst)
        (output_pc_valid && !output_pc_ready)
        |=> (output_pc_valid && $stable(output_pc_and_current)));

endmodule

//--- engine.sv
////////////////////////////////////////////////////////////////////////////
// basic block of the regex matching engine
// tagged PCs go into a ping-pong pair of FIFOs, the regex CPU drains the
// current-character FIFO while enable is high and fetches from wide memory
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module engine #(
    parameter int FIFO_COUNT_WIDTH  = 3,
    parameter int MEMORY_WIDTH      = 32,
    parameter int MEMORY_ADDR_WIDTH = 7
)(
    input  logic                         clk,
    input  logic                         rst,
    output logic                         accepts,
    output logic                         running,
    input  logic                         enable,
    output logic                         full,
    input  logic                         cur_is_even_character,
    input  regex_pkg::char_t             current_character,
    input  logic                         input_pc_valid,
    input  regex_pkg::tagged_pc_t        input_pc_and_current,
    output logic                         input_pc_ready,
    output logic [FIFO_COUNT_WIDTH-1:0]  input_pc_latency,
    output logic                         memory_valid,
    output logic [MEMORY_ADDR_WIDTH-1:0] memory_addr,
    input  logic                         memory_ready,
    input  logic [MEMORY_WIDTH-1:0]      memory_data,
    output logic                         output_pc_valid,
    output regex_pkg::tagged_pc_t        output_pc_and_current,
    input  logic                         output_pc_ready
);
    // FIFO pair
    logic                        cur_in_valid;
    logic                        cur_in_ready;
    logic                        cur_out_valid;
    regex_pkg::pc_t              cur_out_data;
    logic                        cur_out_ready;
    logic [FIFO_COUNT_WIDTH-1:0] cur_count;
    logic                        next_in_valid;
    logic                        next_in_ready;
    // CPU side
    logic                        cpu_pc_in_valid;
    logic                        cpu_pc_in_ready;
    logic                        cpu_busy;
    logic                        fetch_valid;
    logic                        fetch_ready;
    regex_pkg::pc_t              fetch_addr;
    regex_pkg::instr_t           instr;

    ////////////////////////////////////////////////////////////////////////////
    // input demux and status
    ////////////////////////////////////////////////////////////////////////////

    // ready waits for both FIFOs so it never depends on the tag
    assign input_pc_ready = cur_in_ready && next_in_ready;
    assign full           = !input_pc_ready;
    assign cur_in_valid   = input_pc_valid && input_pc_ready && input_pc_and_current.current;
    assign next_in_valid  = input_pc_valid && input_pc_ready && !input_pc_and_current.current;

    // latency looks at the current FIFO only and saturates at all ones
    assign input_pc_latency = (&cur_count) ? cur_count : cur_count + 1'b1;
    assign running          = cur_out_valid || cpu_busy;

    // enable lets the CPU take pcs from the current FIFO
    assign cpu_pc_in_valid = enable && cur_out_valid;
    assign cur_out_ready   = enable && cpu_pc_in_ready;

    ping_pong_buffer #(
        .FIFO_COUNT_WIDTH (FIFO_COUNT_WIDTH)
    ) i_buffer (
        .clk                   (clk),
        .rst                   (rst),
        .cur_is_even_character (cur_is_even_character),
        .cur_in_valid          (cur_in_valid),
        .cur_in_data           (input_pc_and_current.pc),
        .cur_in_ready          (cur_in_ready),
        .cur_out_valid         (cur_out_valid),
        .cur_out_data          (cur_out_data),
        .cur_out_ready         (cur_out_ready),
        .cur_count             (cur_count),
        .next_in_valid         (next_in_valid),
        .next_in_data          (input_pc_and_current.pc),
        .next_in_ready         (next_in_ready)
    );

    regex_cpu i_cpu (
        .clk                   (clk),
        .rst                   (rst),
        .current_character     (current_character),
        .pc_in_valid           (cpu_pc_in_valid),
        .pc_in                 (cur_out_data),
        .pc_in_ready           (cpu_pc_in_ready),
        .fetch_valid           (fetch_valid),
        .fetch_addr            (fetch_addr),
        .fetch_ready           (fetch_ready),
        .instr                 (instr),
        .output_pc_valid       (output_pc_valid),
        .output_pc_and_current (output_pc_and_current),
        .output_pc_ready       (output_pc_ready),
        .accepts               (accepts),
        .busy                  (cpu_busy)
    );

    instr_fetch #(
        .MEMORY_WIDTH      (MEMORY_WIDTH),
        .MEMORY_ADDR_WIDTH (MEMORY_ADDR_WIDTH)
    ) i_fetch (
        .clk          (clk),
        .fetch_valid  (fetch_valid),
        .fetch_addr   (fetch_addr),
        .fetch_ready  (fetch_ready),
        .instr        (instr),
        .memory_valid (memory_valid),
        .memory_addr  (memory_addr),
        .memory_ready (memory_ready),
        .memory_data  (memory_data)
    );

endmodule

//--- tb_engine.sv
////////////////////////////////////////////////////////////////////////////
// self-checking testbench for the regex engine basic block
// reads program image and test records from engine_vectors.txt, models the
// wide instruction memory and checks every output PC, accept and status
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module tb_engine;
    localparam int SEED           = 13457;
    localparam int TIMEOUT_FACTOR = 200;
    localparam int MAX_RECORDS    = 32;

    logic                  clk = 1'b0;
    logic                  rst;
    logic                  enable;
    logic                  cur_is_even_character;
    regex_pkg::char_t      current_character;
    logic                  input_pc_valid;
    regex_pkg::tagged_pc_t input_pc_and_current;
    logic                  memory_ready = 1'b0;
    logic [31:0]           memory_data = '0;
    logic                  output_pc_ready = 1'b0;
    logic                  accepts;
    logic                  running;
    logic                  full;
    logic                  input_pc_ready;
    logic                  memory_valid;
    logic                  output_pc_valid;
    logic [2:0]            input_pc_latency;
    logic [6:0]            memory_addr;
    regex_pkg::tagged_pc_t output_pc_and_current;

    // program image and the word address of the last memory transfer
    logic [31:0]           image [0:127];
    logic [6:0]            rd_addr = '0;
    // test records with fields even, char, tagged pc, n, out0, out1 and accepts
    string                 rec_kind [MAX_RECORDS];
    string                 rec_name [MAX_RECORDS];
    logic [15:0]           rec_field [MAX_RECORDS][7];
    int                    n_rec = 0;
    int                    limit = 1000;
    int                    cycles = 0;
    // observed and modelled results of one record
    regex_pkg::tagged_pc_t out_q [$];
    regex_pkg::tagged_pc_t model_q [$];
    regex_pkg::pc_t        held_q [$];
    int                    acc_seen = 0;
    int                    model_acc = 0;

    engine i_engine (.*);

    always #2 clk = ~clk;

    ////////////////////////////////////////////////////////////////////////////
    // memory model, random stalls, output monitor and timeout
    ////////////////////////////////////////////////////////////////////////////
    always @(posedge clk)
    begin
        if (memory_valid && memory_ready)
            rd_addr <= memory_addr;
    end

    // word answers in the cycle after the transfer
    always @(negedge clk)
    begin
        memory_data     <= image[rd_addr];
        memory_ready    <= ($urandom % 4) != 0;
        output_pc_ready <= ($urandom % 3) != 0;
    end

    always @(posedge clk)
    begin
        if (!rst && output_pc_valid && output_pc_ready)
            out_q.push_back(output_pc_and_current);
        if (!rst && accepts)
            acc_seen++;
    end

    always @(posedge clk)
    begin
        cycles++;
        if (cycles > limit)
        begin
            $display("timeout, the engine did not finish within %0d cycles", limit);
            $display("STATUS: FAIL");
            $fatal(1, "simulation timed out");
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // compare tasks
    ////////////////////////////////////////////////////////////////////////////
    task automatic check_pc(input string name, input regex_pkg::tagged_pc_t exp,
                            input regex_pkg::tagged_pc_t act);
        if (exp !== act)
        begin
            $display("[ERROR] %s expected %h actual %h", name, exp, act);
            $display("STATUS: FAIL");
            $fatal(1, "tagged pc mismatch");
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (exp !== act)
        begin
            $display("[ERROR] %s expected %b actual %b", name, exp, act);
            $display("STATUS: FAIL");
            $fatal(1, "status bit mismatch");
        end
    endtask

    task automatic check_latency(input string name, input logic [2:0] exp,
                                 input logic [2:0] act);
        if (exp !== act)
        begin
            $display("[ERROR] %s expected %0d actual %0d", name, exp, act);
            $display("STATUS: FAIL");
            $fatal(1, "latency mismatch");
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (exp != act)
        begin
            $display("[ERROR] %s expected %0d actual %0d", name, exp, act);
            $display("STATUS: FAIL");
            $fatal(1, "count mismatch");
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // reference model and stimulus helpers
    ////////////////////////////////////////////////////////////////////////////

    // executes one pc from the image, opcode in 15..13 and operand in 7..0
    task automatic model_exec(input regex_pkg::pc_t pc, input regex_pkg::char_t ch);
        logic [31:0] word;
        logic [15:0] ins;
        word = image[pc[7:1]];
        // odd pcs live in the upper half of the word
        ins = pc[0] ? word[31:16] : word[15:0];
        case (ins[15:13])
            3'd0: model_acc++;
            3'd1:
            begin
                if (ins[7:0] == ch)
                    model_q.push_back({pc + 8'd1, 1'b0});
            end
            3'd2:
            begin
                model_q.push_back({pc + 8'd1, 1'b1});
                model_q.push_back({ins[7:0], 1'b1});
            end
            3'd3: model_q.push_back({ins[7:0], 1'b1});
            default: ;
        endcase
    endtask

    // called on a falling edge, returns on the falling edge after the transfer
    task automatic push_pc(input regex_pkg::tagged_pc_t tpc);
        input_pc_and_current = tpc;
        input_pc_valid       = 1'b1;
        do
        begin
            @(posedge clk);
        end
        while (!input_pc_ready);
        @(negedge clk);
        input_pc_valid = 1'b0;
    endtask

    task automatic wait_idle;
        @(negedge clk);
        while (running)
            @(negedge clk);
    endtask

    task automatic load_vectors;
        int          fd;
        int          code;
        int          addr;
        logic [31:0] word;
        logic [31:0] f [7];
        string       line;
        string       kind;
        string       name;
        // unused words hold illegal opcodes tagged with their address
        for (int a = 0; a < 128; a++)
            image[a] = 32'hE000_E000 | (a << 16) | a;
        fd = $fopen("engine_vectors.txt", "r");
        if (fd == 0)
        begin
            $display("the vector file engine_vectors.txt could not be opened");
            $display("STATUS: FAIL");
            $fatal(1, "missing vector file");
        end
        while (!$feof(fd))
        begin
            code = $fgets(line, fd);
            // skip blank lines and '#' comments
            if (code > 0 && line.len() > 1 && line[0] != 8'h23)
            begin
                code = $sscanf(line, "%s", kind);
                if (kind == "M")
                begin
                    code = $sscanf(line, "%s %h %h", kind, addr, word);
                    image[addr] = word;
                end
                else
                begin
                    code = $sscanf(line, "%s %s %h %h %h %h %h %h %h", kind, name,
                                   f[0], f[1], f[2], f[3], f[4], f[5], f[6]);
                    rec_kind[n_rec] = kind;
                    rec_name[n_rec] = name;
                    for (int k = 0; k < 7; k++)
                        rec_field[n_rec][k] = f[k][15:0];
                    n_rec++;
                end
            end
        end
        $fclose(fd);
    endtask

    // T pushes one pc, R only applies parity and character, L fills with enable low
    task automatic run_record(input int i);
        string                 name;
        regex_pkg::char_t      ch;
        regex_pkg::tagged_pc_t tpc;
        regex_pkg::tagged_pc_t exp_pc [2];
        logic [2:0]            exp_lat;
        int                    n;
        int                    exp_n;
        int                    acc;
        name      = rec_name[i];
        ch        = rec_field[i][1][7:0];
        tpc       = rec_field[i][2][8:0];
        n         = int'(rec_field[i][3]);
        exp_pc[0] = rec_field[i][4][8:0];
        exp_pc[1] = rec_field[i][5][8:0];
        acc       = int'(rec_field[i][6]);
        exp_n     = (rec_kind[i] == "L") ? 0 : n;
        out_q.delete();
        model_q.delete();
        acc_seen  = 0;
        model_acc = 0;
        @(negedge clk);
        enable            = 1'b1;
        current_character = ch;
        // a parity change turns the held next pcs into current ones
        if (rec_field[i][0][0] != cur_is_even_character)
        begin
            cur_is_even_character = rec_field[i][0][0];
            foreach (held_q[k])
                model_exec(held_q[k], ch);
            held_q.delete();
        end
        if (rec_kind[i] == "T")
        begin
            push_pc(tpc);
            if (tpc.current)
                model_exec(tpc.pc, ch);
            else
                held_q.push_back(tpc.pc);
        end
        else if (rec_kind[i] == "L")
        begin
            enable = 1'b0;
            for (int k = 0; k < n; k++)
            begin
                exp_lat = (k + 1 > 7) ? 3'd7 : 3'(k + 1);
                check_latency({name, " latency"}, exp_lat, input_pc_latency);
                push_pc(tpc);
                model_exec(tpc.pc, ch);
            end
            check_latency({name, " final latency"}, rec_field[i][4][2:0], input_pc_latency);
            check_bit({name, " input_pc_ready"}, 1'b0, input_pc_ready);
            check_bit({name, " full"}, 1'b1, full);
            check_bit({name, " running"}, 1'b1, running);
            enable = 1'b1;
        end
        wait_idle();
        // model against the file first, then the DUT against the file
        check_count({name, " model outputs"}, exp_n, model_q.size());
        for (int k = 0; k < exp_n; k++)
            check_pc({name, " model pc"}, exp_pc[k], model_q[k]);
        check_count({name, " model accepts"}, acc, model_acc);
        check_count({name, " outputs"}, exp_n, out_q.size());
        for (int k = 0; k < exp_n; k++)
            check_pc({name, " output pc"}, exp_pc[k], out_q[k]);
        check_count({name, " accepts"}, acc, acc_seen);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////////////////////
    initial
    begin
        rst                   = 1'b1;
        enable                = 1'b0;
        cur_is_even_character = 1'b1;
        current_character     = '0;
        input_pc_valid        = 1'b0;
        input_pc_and_current  = '0;
        void'($urandom(SEED));
        load_vectors();
        limit = TIMEOUT_FACTOR * n_rec;
        repeat (3) @(negedge clk);
        rst = 1'b0;
        check_bit("reset output_pc_valid", 1'b0, output_pc_valid);
        check_bit("reset memory_valid", 1'b0, memory_valid);
        check_bit("reset accepts", 1'b0, accepts);
        check_bit("reset running", 1'b0, running);
        check_bit("reset input_pc_ready", 1'b1, input_pc_ready);
        for (int i = 0; i < n_rec; i++)
            run_record(i);
        $display("STATUS: PASS");
        $finish;
    end

endmodule

//--- engine_vectors.txt
# fields in hex. M <word addr> <word>, pc n sits in word n/2, odd pcs in bits 31..16
# T|R|L <test> <even> <char> <tagged pc> <count> <out0> <out1> <accepts>
# T pushes one pc, R runs what a parity change makes current,
# L fills the current FIFO with enable low (count = pushes, out0 = final latency)
# pc0 CHAR 'a', pc1 ACCEPT, pc2 SPLIT 5, pc3 JMP 1, pc4 CHAR 'b', pc5 ACCEPT
M 00 00002061
M 01 60014005
M 02 00002062
T char_match  1 61 001 1 002 000 0
T char_miss   1 62 001 0 000 000 0
T split       1 61 005 2 007 00b 0
T jump        1 61 007 1 003 000 0
T accept_high 1 61 003 0 000 000 1
T accept_pc5  1 61 00b 0 000 000 1
T next_hold   1 62 008 0 000 000 0
R next_run    0 62 000 1 00a 000 0
T split_odd   0 61 005 2 007 00b 0
L fill        0 61 009 7 007 000 0

//--- verilog.f
regex_pkg.sv
pc_fifo.sv
ping_pong_buffer.sv
instr_fetch.sv
regex_cpu.sv
engine.sv
tb_engine.sv

//--- run_sim.sh
#!/bin/sh
# build and run the engine testbench with Verilator
# the exit status is the simulator's, non-zero on any failure

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_engine -f verilog.f -o Vtb_engine
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vtb_engine
status=$?
if [ $status -ne 0 ]; then
    echo "simulation ended with status $status"
    exit $status
fi

echo "simulation finished"
exit 0
